/* build.f */
+incdir+rtl
+incdir+test
rtl/videoPkg.sv
rtl/gamePkg.sv
rtl/vgaTiming.sv
rtl/spriteHit.sv
rtl/glyphRom.sv
rtl/colorMapper.sv
rtl/arcadeDisplay.sv
test/tbArcadeDisplay.sv

/* run.sh */
#!/bin/sh
# Build and run the arcade display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module tbArcadeDisplay \
	-Mdir obj_dir -o simArcadeDisplay
./obj_dir/simArcadeDisplay > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* test/pixelModel.svh */
//--------------------------------------------------------------------------
// Pixel reference model
// Expected RGB and sync levels for one raster coordinate and game state
//--------------------------------------------------------------------------
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

`include "arcadeDisplay_defs.svh"

// Digit bitmaps, 16 rows of 8 bits each, top row in the high byte
localparam logic [127:0] modelFont [10] = '{
	128'h0000_7CC6_C6CE_DEF6_E6C6_C67C_0000_0000,
	128'h0000_1838_7818_1818_1818_187E_0000_0000,
	128'h0000_7CC6_060C_1830_60C0_C6FE_0000_0000,
	128'h0000_7CC6_0606_3C06_0606_C67C_0000_0000,
	128'h0000_0C1C_3C6C_CCFE_0C0C_0C1E_0000_0000,
	128'h0000_FEC0_C0C0_FC06_0606_C67C_0000_0000,
	128'h0000_3860_C0C0_FCC6_C6C6_C67C_0000_0000,
	128'h0000_FEC6_0606_0C18_3030_3030_0000_0000,
	128'h0000_7CC6_C6C6_7CC6_C6C6_C67C_0000_0000,
	128'h0000_7CC6_C6C6_7E06_0606_0C78_0000_0000
};

function automatic logic [7:0] fontRow(input int digit, input int row);
	return modelFont[digit][127 - 8 * row -: 8];
endfunction

// Half-open rectangle test in plain integers, no wrap
function automatic logic inRect(input int x, input int y, input int ox, input int oy,
		input int w, input int h);
	return (x >= ox) && (x < ox + w) && (y >= oy) && (y < oy + h);
endfunction

// hSync, vSync, visible
function automatic logic [2:0] expectedTiming(input coordT x, input coordT y);
	int xi;
	int yi;
	xi = int'(x);
	yi = int'(y);
	return {!(xi >= `H_SYNC_START && xi < `H_SYNC_END),
		!(yi >= `V_SYNC_START && yi < `V_SYNC_END),
		(xi < `H_VISIBLE) && (yi < `V_VISIBLE)};
endfunction

function automatic logic [23:0] expectedPixel(input coordT x, input coordT y,
		input coordT pX, input coordT pY, input coordT mX, input coordT mY,
		input logic mActive, input coordT aBase, input coordT aRow,
		input logic [`NUM_ALIENS-1:0] alive, input scoreT sc, input levelT lv);
	int         xi;
	int         yi;
	int         cellCol;
	int         digit;
	logic [7:0] rowBits;
	xi = int'(x);
	yi = int'(y);
	cellCol = -1;
	digit = 0;
	if (!((xi < `H_VISIBLE) && (yi < `V_VISIBLE)))
		return 24'h000000;
	// Glyph cells win over every object
	if (yi >= `GLYPH_ROW_TOP && yi <= `GLYPH_ROW_BOTTOM) begin
		if (xi >= `LEVEL_COL && xi < `LEVEL_COL + `GLYPH_W) begin
			cellCol = `LEVEL_COL;
			digit = int'(lv);
		end else if (xi >= `SCORE_TENS_COL && xi < `SCORE_TENS_COL + `GLYPH_W) begin
			cellCol = `SCORE_TENS_COL;
			digit = int'(sc) / 10;
		end else if (xi >= `SCORE_ONES_COL && xi < `SCORE_ONES_COL + `GLYPH_W) begin
			cellCol = `SCORE_ONES_COL;
			digit = int'(sc) % 10;
		end
	end
	if (cellCol >= 0) begin
		rowBits = fontRow(digit, yi - `GLYPH_ROW_TOP);
		return rowBits[7 - (xi - cellCol)] ? 24'hFFFFFF : 24'h000000;
	end
	if (mActive && inRect(xi, yi, int'(mX), int'(mY), `MISSILE_W, `MISSILE_H))
		return 24'hFF0000;
	if (inRect(xi, yi, int'(pX), int'(pY), `PLAYER_W, `PLAYER_H))
		return 24'hFFFFFF;
	for (int i = 0; i < `NUM_ALIENS; i++) begin
		if (alive[i] && inRect(xi, yi, int'(aBase) + i * `ALIEN_SPACING, int'(aRow),
				`ALIEN_W, `ALIEN_H))
			return 24'h00FF00;
	end
	return 24'h000000;
endfunction

`endif

/* test/tbArcadeDisplay.sv */
//--------------------------------------------------------------------------
// Arcade display testbench
// Random game frames checked pixel by pixel against the reference model
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "arcadeDisplay_defs.svh"

module tbArcadeDisplay import videoPkg::*, gamePkg::*; ();

	typedef logic [`NUM_ALIENS-1:0] aliveMaskT;

	// Expected output sample held until the DUT pipeline catches up
	typedef struct packed {
		logic        isReset;
		coordT       x;
		coordT       y;
		logic [23:0] rgb;
		logic [2:0]  timing;
	} expectT;

	localparam int frameCycles   = `H_TOTAL * `V_TOTAL;
	localparam int timeoutCycles = 4 * frameCycles + 100;
	// State changes only on this blank line
	localparam int blankLine     = 500;

	logic      clk = 1'b0;
	logic      rstN;
	coordT     playerX;
	coordT     playerY;
	coordT     missileX;
	coordT     missileY;
	logic      missileActive;
	coordT     alienBaseX;
	coordT     alienRowY;
	aliveMaskT alienAlive;
	scoreT     score;
	levelT     level;
	colorChanT vgaR;
	colorChanT vgaG;
	colorChanT vgaB;
	logic      hSync;
	logic      vSync;
	logic      visible;

	int     seed = 2;
	coordT  tbX = '0;
	coordT  tbY = '0;
	int     framesDone = 0;
	int     cycleCount = 0;
	int     checkCount = 0;
	int     pixelErrors = 0;
	int     timingErrors = 0;
	expectT expQ[$];

	`include "pixelModel.svh"

	arcadeDisplay arcadeDisplay_inst (
		.clk           (clk),
		.rstN          (rstN),
		.playerX       (playerX),
		.playerY       (playerY),
		.missileX      (missileX),
		.missileY      (missileY),
		.missileActive (missileActive),
		.alienBaseX    (alienBaseX),
		.alienRowY     (alienRowY),
		.alienAlive    (alienAlive),
		.score         (score),
		.level         (level),
		.vgaR          (vgaR),
		.vgaG          (vgaG),
		.vgaB          (vgaB),
		.hSync         (hSync),
		.vSync         (vSync),
		.visible       (visible)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	function automatic int randBelow(input int n);
		return int'(($random(seed) & 32'h7FFF_FFFF) % n);
	endfunction

	// Region label for error lines
	function automatic string testNameOf(input expectT e);
		int xi;
		int yi;
		xi = int'(e.x);
		yi = int'(e.y);
		if (e.isReset)
			return "reset";
		if (!e.timing[0])
			return "blanking";
		if (yi >= `GLYPH_ROW_TOP && yi <= `GLYPH_ROW_BOTTOM) begin
			if (xi >= `LEVEL_COL && xi < `LEVEL_COL + `GLYPH_W)
				return "level glyph";
			if (xi >= `SCORE_TENS_COL && xi < `SCORE_TENS_COL + `GLYPH_W)
				return "score tens";
			if (xi >= `SCORE_ONES_COL && xi < `SCORE_ONES_COL + `GLYPH_W)
				return "score ones";
		end
		case (e.rgb)
			24'hFF0000: return "missile";
			24'hFFFFFF: return "player";
			24'h00FF00: return "aliens";
			default:    return "background";
		endcase
	endfunction

	//----------------------------------------------------------------------
	// Frame setup
	//----------------------------------------------------------------------
	task automatic newFrame(input int f);
		coordT     baseX;
		coordT     rowY;
		aliveMaskT mask;
		baseX = coordT'(32 + randBelow(320));
		rowY  = coordT'(40 + randBelow(200));
		// Aliens 0 and 2 always alive and alien 5 always dead
		mask  = (aliveMaskT'(randBelow(256)) | aliveMaskT'(8'h05)) & aliveMaskT'(8'hDF);
		if (f == 3) begin
			// Alien row across the score cells
			baseX = coordT'(370);
			rowY  = coordT'(444);
			mask  = mask | aliveMaskT'(8'h80);
		end
		alienBaseX <= baseX;
		alienRowY  <= rowY;
		alienAlive <= mask;
		level      <= levelT'(f);
		score      <= scoreT'(randBelow(100));
		if (f % 2 == 0) begin
			// Missile inside player inside alien 0
			playerX       <= baseX + coordT'(4);
			playerY       <= rowY + coordT'(4);
			missileX      <= baseX + coordT'(10);
			missileY      <= rowY + coordT'(6);
			missileActive <= 1'b1;
		end else begin
			// Player across the level cell and idle missile over alien 2
			playerX       <= coordT'(36);
			playerY       <= coordT'(446);
			missileX      <= baseX + coordT'(71);
			missileY      <= rowY + coordT'(4);
			missileActive <= 1'b0;
		end
	endtask

	//----------------------------------------------------------------------
	// Own raster counter and timeout
	//----------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rstN) begin
			tbX <= '0;
			tbY <= '0;
		end else if (tbX == coordT'(`H_TOTAL - 1)) begin
			tbX <= '0;
			if (tbY == coordT'(`V_TOTAL - 1)) begin
				tbY        <= '0;
				framesDone <= framesDone + 1;
			end else begin
				tbY <= tbY + 1'b1;
			end
		end else begin
			tbX <= tbX + 1'b1;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Compare on the falling edge where outputs are settled
	//----------------------------------------------------------------------
	always @(negedge clk) begin
		expectT e;
		expectT old;
		string  name;
		e.isReset = !rstN;
		e.x       = tbX;
		e.y       = tbY;
		if (!rstN) begin
			e.rgb    = 24'h000000;
			e.timing = 3'b110;
		end else begin
			e.rgb = expectedPixel(tbX, tbY, playerX, playerY, missileX, missileY,
				missileActive, alienBaseX, alienRowY, alienAlive, score, level);
			e.timing = expectedTiming(tbX, tbY);
		end
		expQ.push_back(e);
		// Output now shows the coordinate from two cycles back
		if (expQ.size() > `PIPE_DEPTH) begin
			old = expQ.pop_front();
			name = testNameOf(old);
			checkCount++;
			assert ({vgaR, vgaG, vgaB} == old.rgb) else begin
				pixelErrors++;
				$display("FAILED %s at (%0d,%0d): expected rgb %06h, actual %06h",
					name, old.x, old.y, old.rgb, {vgaR, vgaG, vgaB});
			end
			// Bits are hSync, vSync, visible
			assert ({hSync, vSync, visible} == old.timing) else begin
				timingErrors++;
				$display("FAILED raster timing at (%0d,%0d): expected %03b, actual %03b",
					old.x, old.y, old.timing, {hSync, vSync, visible});
			end
		end
	end

	//----------------------------------------------------------------------
	// Stimulus and report
	//----------------------------------------------------------------------
	initial begin
		rstN          = 1'b0;
		playerX       = '0;
		playerY       = '0;
		missileX      = '0;
		missileY      = '0;
		missileActive = 1'b0;
		alienBaseX    = '0;
		alienRowY     = '0;
		alienAlive    = '0;
		score         = '0;
		level         = '0;
		@(posedge clk);
		newFrame(0);
		// Reset low for 16 rising edges
		repeat (15) @(posedge clk);
		rstN <= 1'b1;
		for (int f = 1; f < 4; f++) begin
			@(posedge clk);
			while (!(tbX == '0 && tbY == coordT'(blankLine)))
				@(posedge clk);
			newFrame(f);
		end
		while (framesDone < 4)
			@(posedge clk);
		// Drain the pipeline
		repeat (`PIPE_DEPTH + 1) @(posedge clk);
		$display("Checks: %0d, pixel errors: %0d, timing errors: %0d",
			checkCount, pixelErrors, timingErrors);
		if (pixelErrors == 0 && timingErrors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* rtl/arcadeDisplay.sv */
//--------------------------------------------------------------------------
// Arcade display top
// Raster timing, object hit testers and color mapper for one VGA frame
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "arcadeDisplay_defs.svh"

module arcadeDisplay import videoPkg::*, gamePkg::*; (
	input  logic                   clk,
	input  logic                   rstN,
	input  coordT                  playerX,
	input  coordT                  playerY,
	input  coordT                  missileX,
	input  coordT                  missileY,
	input  logic                   missileActive,
	input  coordT                  alienBaseX,
	input  coordT                  alienRowY,
	input  logic [`NUM_ALIENS-1:0] alienAlive,
	input  scoreT                  score,
	input  levelT                  level,
	output colorChanT              vgaR,
	output colorChanT              vgaG,
	output colorChanT              vgaB,
	output logic                   hSync,
	output logic                   vSync,
	output logic                   visible
);

	coordT                  drawX;
	coordT                  drawY;
	logic                   hSyncRaw;
	logic                   vSyncRaw;
	logic                   rawVisible;
	logic [`NUM_ALIENS-1:0] alienHit;
	logic                   playerHit;
	logic                   missileHit;

	//----------------------------------------------------------------------
	// Raster
	//----------------------------------------------------------------------
	vgaTiming vgaTiming_inst (
		.clk        (clk),
		.rstN       (rstN),
		.drawX      (drawX),
		.drawY      (drawY),
		.hSyncRaw   (hSyncRaw),
		.vSyncRaw   (vSyncRaw),
		.rawVisible (rawVisible)
	);

	//----------------------------------------------------------------------
	// Hit testers
	//----------------------------------------------------------------------
	// Aliens sit on one row at fixed spacing from the base column
	for (genvar i = 0; i < `NUM_ALIENS; i++) begin : genAlien
		coordT alienX;

		assign alienX = alienBaseX + coordT'(i * `ALIEN_SPACING);

		spriteHit #(
			.width  (`ALIEN_W),
			.height (`ALIEN_H)
		) alienHit_inst (
			.clk    (clk),
			.rstN   (rstN),
			.enable (alienAlive[i]),
			.objX   (alienX),
			.objY   (alienRowY),
			.drawX  (drawX),
			.drawY  (drawY),
			.hit    (alienHit[i])
		);
	end

	// Player ship always drawn
	spriteHit #(
		.width  (`PLAYER_W),
		.height (`PLAYER_H)
	) playerHit_inst (
		.clk    (clk),
		.rstN   (rstN),
		.enable (1'b1),
		.objX   (playerX),
		.objY   (playerY),
		.drawX  (drawX),
		.drawY  (drawY),
		.hit    (playerHit)
	);

	spriteHit #(
		.width  (`MISSILE_W),
		.height (`MISSILE_H)
	) missileHit_inst (
		.clk    (clk),
		.rstN   (rstN),
		.enable (missileActive),
		.objX   (missileX),
		.objY   (missileY),
		.drawX  (drawX),
		.drawY  (drawY),
		.hit    (missileHit)
	);

	//----------------------------------------------------------------------
	// Pixel colors
	//----------------------------------------------------------------------
	colorMapper colorMapper_inst (
		.clk        (clk),
		.rstN       (rstN),
		.drawX      (drawX),
		.drawY      (drawY),
		.hSyncRaw   (hSyncRaw),
		.vSyncRaw   (vSyncRaw),
		.rawVisible (rawVisible),
		.alienHit   (alienHit),
		.playerHit  (playerHit),
		.missileHit (missileHit),
		.score      (score),
		.level      (level),
		.vgaR       (vgaR),
		.vgaG       (vgaG),
		.vgaB       (vgaB),
		.hSync      (hSync),
		.vSync      (vSync),
		.visible    (visible)
	);

endmodule

/* rtl/colorMapper.sv */
//--------------------------------------------------------------------------
// Color mapper
// Priority color select with score and level glyphs, registered VGA out
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "arcadeDisplay_defs.svh"

module colorMapper import videoPkg::*, gamePkg::*; (
	input  logic                   clk,
	input  logic                   rstN,
	input  coordT                  drawX,
	input  coordT                  drawY,
	input  logic                   hSyncRaw,
	input  logic                   vSyncRaw,
	input  logic                   rawVisible,
	input  logic [`NUM_ALIENS-1:0] alienHit,
	input  logic                   playerHit,
	input  logic                   missileHit,
	input  scoreT                  score,
	input  levelT                  level,
	output colorChanT              vgaR,
	output colorChanT              vgaG,
	output colorChanT              vgaB,
	output logic                   hSync,
	output logic                   vSync,
	output logic                   visible
);

	coordT      dlyX;
	coordT      dlyY;
	logic       dlyHSync;
	logic       dlyVSync;
	logic       dlyVisible;
	digitT      tensDigit;
	digitT      onesDigit;
	digitT      glyphDigit;
	coordT      colBase;
	logic [3:0] glyphRow;
	logic [2:0] glyphCol;
	logic [7:0] glyphBits;
	logic       inBand;
	logic       inLevel;
	logic       inTens;
	logic       inOnes;
	logic       glyphPixel;
	colorChanT  nextR;
	colorChanT  nextG;
	colorChanT  nextB;

	//----------------------------------------------------------------------
	// Align coordinates and syncs with the registered hit flags
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		dlyX <= drawX;
		dlyY <= drawY;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dlyHSync   <= 1'b1;
			dlyVSync   <= 1'b1;
			dlyVisible <= 1'b0;
		end else begin
			dlyHSync   <= hSyncRaw;
			dlyVSync   <= vSyncRaw;
			dlyVisible <= rawVisible;
		end
	end

	//----------------------------------------------------------------------
	// Glyph band decode
	//----------------------------------------------------------------------
	// Score drawn tens first
	assign tensDigit = digitT'(score / scoreT'(10));
	assign onesDigit = digitT'(score % scoreT'(10));

	assign inBand  = (dlyY >= coordT'(`GLYPH_ROW_TOP)) &&
		(dlyY <= coordT'(`GLYPH_ROW_BOTTOM));
	assign inLevel = inBand && (dlyX >= coordT'(`LEVEL_COL)) &&
		(dlyX < coordT'(`LEVEL_COL + `GLYPH_W));
	assign inTens  = inBand && (dlyX >= coordT'(`SCORE_TENS_COL)) &&
		(dlyX < coordT'(`SCORE_TENS_COL + `GLYPH_W));
	assign inOnes  = inBand && (dlyX >= coordT'(`SCORE_ONES_COL)) &&
		(dlyX < coordT'(`SCORE_ONES_COL + `GLYPH_W));

	// Only one cell can hold the pixel, so one ROM is shared
	always_comb begin
		if (inLevel) begin
			glyphDigit = digitT'(level);
			colBase    = coordT'(`LEVEL_COL);
		end else if (inTens) begin
			glyphDigit = tensDigit;
			colBase    = coordT'(`SCORE_TENS_COL);
		end else begin
			glyphDigit = onesDigit;
			colBase    = coordT'(`SCORE_ONES_COL);
		end
	end

	assign glyphRow = 4'(dlyY - coordT'(`GLYPH_ROW_TOP));
	assign glyphCol = 3'(dlyX - colBase);

	glyphRom glyphRom_inst (
		.digit (glyphDigit),
		.row   (glyphRow),
		.bits  (glyphBits)
	);

	// Leftmost column is bit 7
	assign glyphPixel = glyphBits[3'd7 - glyphCol];

	//----------------------------------------------------------------------
	// Priority select
	//----------------------------------------------------------------------
	always_comb begin
		nextR = chanOff;
		nextG = chanOff;
		nextB = chanOff;
		if (!dlyVisible) begin
			// Blanking stays black
			nextR = chanOff;
		end else if (inLevel || inTens || inOnes) begin
			// Glyph cells override every object
			if (glyphPixel) begin
				nextR = chanFull;
				nextG = chanFull;
				nextB = chanFull;
			end
		end else if (missileHit) begin
			nextR = chanFull;
		end else if (playerHit) begin
			nextR = chanFull;
			nextG = chanFull;
			nextB = chanFull;
		end else if (|alienHit) begin
			nextG = chanFull;
		end
	end

	// Output stage
	always_ff @(posedge clk) begin
		if (!rstN) begin
			vgaR    <= chanOff;
			vgaG    <= chanOff;
			vgaB    <= chanOff;
			hSync   <= 1'b1;
			vSync   <= 1'b1;
			visible <= 1'b0;
		end else begin
			vgaR    <= nextR;
			vgaG    <= nextG;
			vgaB    <= nextB;
			hSync   <= dlyHSync;
			vSync   <= dlyVSync;
			visible <= dlyVisible;
		end
	end

	// Blank pixels leave the DAC dark
	blackWhenBlank: assert property (@(posedge clk) disable iff (!rstN)
		!visible |-> (vgaR == chanOff) && (vgaG == chanOff) && (vgaB == chanOff));

	// Score and level held across the drawn lines, score fits two digits
	hudStableInFrame: assert property (@(posedge clk) disable iff (!rstN)
		(drawY > 0) && (drawY < coordT'(`V_VISIBLE)) |->
		$stable(score) && $stable(level) && (score <= maxScore));

endmodule

/* rtl/glyphRom.sv */
//--------------------------------------------------------------------------
// Glyph ROM
// 8x16 bitmaps for the digits 0 to 9, MSB is the leftmost column
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module glyphRom import gamePkg::*; (
	input  digitT      digit,
	input  logic [3:0] row,
	output logic [7:0] bits
);

	//----------------------------------------------------------------------
	// Bitmap table, 16 rows per digit
	//----------------------------------------------------------------------
	localparam logic [7:0] fontTable [0:159] = '{
		// 0
		8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hCE, 8'hDE, 8'hF6,
		8'hE6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00,
		// 1
		8'h00, 8'h00, 8'h18, 8'h38, 8'h78, 8'h18, 8'h18, 8'h18,
		8'h18, 8'h18, 8'h18, 8'h7E, 8'h00, 8'h00, 8'h00, 8'h00,
		// 2
		8'h00, 8'h00, 8'h7C, 8'hC6, 8'h06, 8'h0C, 8'h18, 8'h30,
		8'h60, 8'hC0, 8'hC6, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h00,
		// 3
		8'h00, 8'h00, 8'h7C, 8'hC6, 8'h06, 8'h06, 8'h3C, 8'h06,
		8'h06, 8'h06, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00,
		// 4
		8'h00, 8'h00, 8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'hCC, 8'hFE,
		8'h0C, 8'h0C, 8'h0C, 8'h1E, 8'h00, 8'h00, 8'h00, 8'h00,
		// 5
		8'h00, 8'h00, 8'hFE, 8'hC0, 8'hC0, 8'hC0, 8'hFC, 8'h06,
		8'h06, 8'h06, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00,
		// 6
		8'h00, 8'h00, 8'h38, 8'h60, 8'hC0, 8'hC0, 8'hFC, 8'hC6,
		8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00,
		// 7
		8'h00, 8'h00, 8'hFE, 8'hC6, 8'h06, 8'h06, 8'h0C, 8'h18,
		8'h30, 8'h30, 8'h30, 8'h30, 8'h00, 8'h00, 8'h00, 8'h00,
		// 8
		8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'hC6,
		8'hC6, 8'hC6, 8'hC6, 8'h7C, 8'h00, 8'h00, 8'h00, 8'h00,
		// 9
		8'h00, 8'h00, 8'h7C, 8'hC6, 8'hC6, 8'hC6, 8'h7E, 8'h06,
		8'h06, 8'h06, 8'h0C, 8'h78, 8'h00, 8'h00, 8'h00, 8'h00
	};

	logic [7:0] tableIndex;

	// Digit selects the 16-row block, row the line inside it
	assign tableIndex = {digit, row};

	// Codes above 9 draw as blank
	always_comb begin
		if (digit <= 4'd9)
			bits = fontTable[tableIndex];
		else
			bits = 8'h00;
	end

endmodule

/* rtl/spriteHit.sv */
//--------------------------------------------------------------------------
// Sprite hit tester
// Registered flag for the current pixel inside one object rectangle
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "arcadeDisplay_defs.svh"

module spriteHit import videoPkg::*; #(
	parameter int width  = 16,
	parameter int height = 16
) (
	input  logic  clk,
	input  logic  rstN,
	input  logic  enable,
	input  coordT objX,
	input  coordT objY,
	input  coordT drawX,
	input  coordT drawY,
	output logic  hit
);

	// One extra bit so objects near the raster edge do not wrap
	logic [10:0] rightEdge;
	logic [10:0] bottomEdge;
	logic        insideX;
	logic        insideY;

	assign rightEdge  = {1'b0, objX} + 11'(width);
	assign bottomEdge = {1'b0, objY} + 11'(height);

	// Half-open rectangle [obj, obj + size)
	assign insideX = (drawX >= objX) && ({1'b0, drawX} < rightEdge);
	assign insideY = (drawY >= objY) && ({1'b0, drawY} < bottomEdge);

	always_ff @(posedge clk) begin
		if (!rstN)
			hit <= 1'b0;
		else
			hit <= enable && insideX && insideY;
	end

	// Disabled object leaves no trace on the next pixel
	noHitWhenDisabled: assert property (@(posedge clk) disable iff (!rstN)
		!enable |=> !hit);

	// Object state may only move during vertical blank
	objStableInFrame: assert property (@(posedge clk) disable iff (!rstN)
		(drawY > 0) && (drawY < coordT'(`V_VISIBLE)) |->
		$stable(objX) && $stable(objY) && $stable(enable));

endmodule

/* rtl/vgaTiming.sv */
//--------------------------------------------------------------------------
// VGA timing generator
// 800x525 raster counters with sync and visible-area flags
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`include "arcadeDisplay_defs.svh"

module vgaTiming import videoPkg::*; (
	input  logic  clk,
	input  logic  rstN,
	output coordT drawX,
	output coordT drawY,
	output logic  hSyncRaw,
	output logic  vSyncRaw,
	output logic  rawVisible
);

	coordT hCount;
	coordT vCount;
	logic  lineEnd;
	logic  frameEnd;

	// Last pixel of a line, last line of a frame
	assign lineEnd  = (hCount == coordT'(`H_TOTAL - 1));
	assign frameEnd = (vCount == coordT'(`V_TOTAL - 1));

	//----------------------------------------------------------------------
	// Raster counters
	//----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			// Line counter steps once per line
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	assign drawX = hCount;
	assign drawY = vCount;

	//----------------------------------------------------------------------
	// Sync and blanking
	//----------------------------------------------------------------------
	// Both syncs active low
	assign hSyncRaw = !((hCount >= coordT'(`H_SYNC_START)) &&
		(hCount < coordT'(`H_SYNC_END)));
	assign vSyncRaw = !((vCount >= coordT'(`V_SYNC_START)) &&
		(vCount < coordT'(`V_SYNC_END)));

	// Drawable 640x480 region
	assign rawVisible = (hCount < coordT'(`H_VISIBLE)) &&
		(vCount < coordT'(`V_VISIBLE));

	// Counters never leave the raster
	hCountInRange: assert property (@(posedge clk) disable iff (!rstN)
		hCount < coordT'(`H_TOTAL));
	vCountInRange: assert property (@(posedge clk) disable iff (!rstN)
		vCount < coordT'(`V_TOTAL));

endmodule

/* rtl/gamePkg.sv */
//--------------------------------------------------------------------------
// Game state types
// Score, level and glyph index as seen by the display
//--------------------------------------------------------------------------
package gamePkg;

	// Two decimal digits of score
	typedef logic [6:0] scoreT;

	// Level 0 to 3
	typedef logic [1:0] levelT;

	// Glyph index, digits 0 to 9
	typedef logic [3:0] digitT;

	// Largest score the two-digit display can show
	localparam scoreT maxScore = 7'd99;

endpackage

/* rtl/videoPkg.sv */
//--------------------------------------------------------------------------
// Video types
// Raster coordinates and color channel values
//--------------------------------------------------------------------------
package videoPkg;

	// Pixel coordinate, covers the full 800x525 raster
	typedef logic [9:0] coordT;

	// One VGA color channel
	typedef logic [7:0] colorChanT;

	// Channel levels used by the palette
	localparam colorChanT chanFull = 8'hFF;
	localparam colorChanT chanOff  = 8'h00;

endpackage

/* rtl/arcadeDisplay_defs.svh */
//--------------------------------------------------------------------------
// Arcade display constants
// Raster sizes, object sizes and glyph placement for the VGA back end
//--------------------------------------------------------------------------
`ifndef ARCADE_DISPLAY_DEFS_SVH
`define ARCADE_DISPLAY_DEFS_SVH

// Horizontal raster, in pixel clocks
`define H_VISIBLE        640
`define H_TOTAL          800
`define H_SYNC_START     656
`define H_SYNC_END       752

// Vertical raster, in lines
`define V_VISIBLE        480
`define V_TOTAL          525
`define V_SYNC_START     490
`define V_SYNC_END       492

// Alien row
`define NUM_ALIENS       8
`define ALIEN_W          16
`define ALIEN_H          16
`define ALIEN_SPACING    32

// Player ship and missile
`define PLAYER_W         16
`define PLAYER_H         8
`define MISSILE_W        2
`define MISSILE_H        8

// Glyph band, 8x16 cells
`define GLYPH_ROW_TOP    450
`define GLYPH_ROW_BOTTOM 465
`define GLYPH_W          8
`define LEVEL_COL        40
`define SCORE_TENS_COL   584
`define SCORE_ONES_COL   592

// Coordinate to pixel output latency
`define PIPE_DEPTH       2

`endif
